//--- include/mcu_params.svh
/*
  MCU coprocessor parameters
  Clock-enable divisor, program memory depth and shared-RAM bus widths
*/
`ifndef MCU_PARAMS_SVH
`define MCU_PARAMS_SVH

// clk cycles per pipeline enable
`define MCU_CEN_DIV 4

// Program memory address width, 256 words
`define MCU_PROG_AW 8

// Shared RAM word address and data widths
`define MCU_XADDR_W 15
`define MCU_XDATA_W 16

`endif

//--- rtl/mcu_bus_pkg.sv
/*
  Shared-RAM bus types
  Wishbone classic request and response for the byte-lane RAM port
*/
`include "mcu_params.svh"

package mcu_bus_pkg;

    // Master to RAM
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [1:0]              sel;   // Bit 1 is lane 15:8
        logic [`MCU_XADDR_W-1:0] adr;
        logic [`MCU_XDATA_W-1:0] dat;
    } wb_req_s;

    // RAM to master, ack is the RAM-ready signal
    typedef struct packed {
        logic                    ack;
        logic [`MCU_XDATA_W-1:0] dat;
    } wb_rsp_s;

endpackage

//--- rtl/mcu_isa_pkg.sv
/*
  MCU instruction set types
  Opcodes, the two views of an instruction word and the decoded control
*/
`include "mcu_params.svh"

package mcu_isa_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_LDI  = 4'h1,
        OP_ADDI = 4'h2,
        OP_LDP  = 4'h3,
        OP_INCP = 4'h4,
        OP_RDX  = 4'h5,
        OP_WRX  = 4'h6,
        OP_OUT  = 4'h7,
        OP_JMP  = 4'h8,
        OP_JNZ  = 4'h9,
        OP_WINT = 4'ha,
        OP_CLRI = 4'hb
    } opcode_e;

    // Immediate view
    typedef struct packed {
        opcode_e    op;
        logic [3:0] rsvd;
        logic [7:0] imm;
    } insn_imm_s;

    // Address view, jump target or pointer load
    typedef struct packed {
        opcode_e     op;
        logic [11:0] addr;
    } insn_adr_s;

    typedef union packed {
        insn_imm_s imm_view;
        insn_adr_s adr_view;
    } insn_u;

    typedef struct packed {
        opcode_e                 op;
        logic [7:0]              imm;
        logic [11:0]             addr;
        logic [`MCU_PROG_AW-1:0] pc;
        logic                    valid;
    } ctrl_s;

endpackage

//--- rtl/mcu_prog_mem.sv
/*
  MCU program memory
  Loaded through the programming port, read synchronously by decode
*/
`timescale 1ns/1ns
`include "mcu_params.svh"

module mcu_prog_mem import mcu_isa_pkg::*; (
    input  logic                    clk,
    // Programming port
    input  logic                    prog_we_i,
    input  logic [`MCU_PROG_AW-1:0] prog_addr_i,
    input  logic [15:0]             prog_data_i,
    // Fetch port
    input  logic [`MCU_PROG_AW-1:0] rd_addr_i,
    output insn_u                   rd_data_o
);

    localparam int DEPTH = 2**`MCU_PROG_AW;

    logic [15:0] mem [DEPTH];

    // Loader writes a word per clk
    always_ff @(posedge clk) begin
        if (prog_we_i) begin
            mem[prog_addr_i] <= prog_data_i;
        end
    end

    // Data follows the address one clk later
    always_ff @(posedge clk) begin
        rd_data_o <= insn_u'(mem[rd_addr_i]);
    end

endmodule

//--- rtl/mcu_decode.sv
/*
  MCU decode stage
  Holds the pc, drives the fetch address and registers the decoded
  control word. A redirect reloads the pc and drops the fetched word.
*/
`timescale 1ns/1ns
`include "mcu_params.svh"

module mcu_decode import mcu_isa_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_cpu,
    input  logic                    cen_i,
    input  logic                    stall_i,
    input  logic                    redirect_i,
    input  logic [`MCU_PROG_AW-1:0] target_i,
    output logic [`MCU_PROG_AW-1:0] mem_addr_o,
    input  insn_u                   mem_data_i,
    output ctrl_s                   ctrl_o
);

    logic [`MCU_PROG_AW-1:0] pc;
    ctrl_s                   dec;

    // Fetch address is the pc itself
    assign mem_addr_o = pc;

    // Opcode picks the view of the word
    always_comb begin
        dec       = '0;
        dec.op    = mem_data_i.imm_view.op;
        dec.pc    = pc;
        dec.valid = 1'b1;
        case (mem_data_i.imm_view.op)
            OP_LDP, OP_JMP, OP_JNZ: dec.addr = mem_data_i.adr_view.addr;
            default:                dec.imm  = mem_data_i.imm_view.imm;
        endcase
    end

    always_ff @(posedge clk or posedge rst_cpu) begin
        if (rst_cpu) begin
            pc     <= '0;
            ctrl_o <= '0;
        end else if (cen_i && !stall_i) begin
            if (redirect_i) begin
                // Word in flight belongs to the wrong path
                pc           <= target_i;
                ctrl_o.valid <= 1'b0;
            end else begin
                pc     <= pc + 1'b1;
                ctrl_o <= dec;
            end
        end
    end

endmodule

//--- rtl/mcu_execute.sv
/*
  MCU execute stage
  Arithmetic, pointer updates and branch resolution on forwarded acc and
  ptr. WINT holds here until the request flag is set.
*/
`timescale 1ns/1ns
`include "mcu_params.svh"

module mcu_execute import mcu_isa_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_cpu,
    input  logic                    cen_i,
    input  logic                    stall_i,
    input  logic                    irq_pend_i,
    input  ctrl_s                   ctrl_i,
    input  logic [7:0]              acc_i,
    input  logic [15:0]             ptr_i,
    output logic                    redirect_o,
    output logic [`MCU_PROG_AW-1:0] target_o,
    output logic                    irq_clr_o,
    output logic                    hold_o,
    // To result stage
    output logic                    wr_acc_o,
    output logic                    wr_ptr_o,
    output logic                    wr_port_o,
    output logic [15:0]             value_o,
    output logic                    mem_rd_o,
    output logic                    mem_wr_o,
    output logic                    valid_o
);

    logic        go;
    logic        step;
    logic [7:0]  acc_fwd;
    logic [15:0] ptr_fwd;
    logic [15:0] value_nxt;

    // Result stage commits on the same enable
    assign acc_fwd = (valid_o && wr_acc_o) ? value_o[7:0] : acc_i;
    assign ptr_fwd = (valid_o && wr_ptr_o) ? value_o : ptr_i;

    // WINT waits for the flag
    assign hold_o = ctrl_i.valid && ctrl_i.op == OP_WINT && !irq_pend_i;
    assign go     = ctrl_i.valid && !hold_o;
    assign step   = cen_i && !stall_i;

    // Taken jumps flush decode
    assign redirect_o = go && (ctrl_i.op == OP_JMP ||
                               (ctrl_i.op == OP_JNZ && acc_fwd != 8'd0));
    assign target_o   = ctrl_i.addr[`MCU_PROG_AW-1:0];

    // Flag clear lasts one enabled cycle
    assign irq_clr_o = step && go && ctrl_i.op == OP_CLRI;

    always_comb begin
        case (ctrl_i.op)
            OP_LDI:  value_nxt = {8'd0, ctrl_i.imm};
            OP_ADDI: value_nxt = {8'd0, acc_fwd + ctrl_i.imm};
            OP_LDP:  value_nxt = {4'd0, ctrl_i.addr};
            OP_INCP: value_nxt = ptr_fwd + 16'd1;
            default: value_nxt = {8'd0, acc_fwd};
        endcase
    end

    // Bubble while WINT holds so nothing commits twice
    always_ff @(posedge clk or posedge rst_cpu) begin
        if (rst_cpu) begin
            valid_o   <= 1'b0;
            wr_acc_o  <= 1'b0;
            wr_ptr_o  <= 1'b0;
            wr_port_o <= 1'b0;
            mem_rd_o  <= 1'b0;
            mem_wr_o  <= 1'b0;
        end else if (step) begin
            valid_o   <= go;
            wr_acc_o  <= go && (ctrl_i.op == OP_LDI || ctrl_i.op == OP_ADDI);
            wr_ptr_o  <= go && (ctrl_i.op == OP_LDP || ctrl_i.op == OP_INCP);
            wr_port_o <= go && ctrl_i.op == OP_OUT;
            mem_rd_o  <= go && ctrl_i.op == OP_RDX;
            mem_wr_o  <= go && ctrl_i.op == OP_WRX;
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            value_o <= value_nxt;
        end
    end

    // Result stage runs one bus cycle per instruction
    a_one_mem_op: assert property (@(posedge clk) disable iff (rst_cpu)
        !(mem_rd_o && mem_wr_o));

endmodule

//--- rtl/mcu_result.sv
/*
  MCU result stage
  Writes back acc, ptr and the output port. Runs the shared-RAM bus
  cycle for RDX and WRX and holds the pipeline until ack.
*/
`timescale 1ns/1ns

module mcu_result import mcu_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst_cpu,
    input  logic        cen_i,
    // From execute
    input  logic        wr_acc_i,
    input  logic        wr_ptr_i,
    input  logic        wr_port_i,
    input  logic [15:0] value_i,
    input  logic        mem_rd_i,
    input  logic        mem_wr_i,
    input  logic        valid_i,
    // Shared RAM
    output wb_req_s     wb_req_o,
    input  wb_rsp_s     wb_rsp_i,
    output logic [7:0]  acc_o,
    output logic [15:0] ptr_o,
    output logic [7:0]  port_o,
    output logic        busy_o
);

    logic       done;
    logic       mem_op;
    logic [7:0] rd_byte;

    assign mem_op = valid_i && (mem_rd_i || mem_wr_i);
    assign busy_o = mem_op && !done;

    // Odd address reads the high lane
    assign rd_byte = ptr_o[0] ? wb_rsp_i.dat[15:8] : wb_rsp_i.dat[7:0];

    always_ff @(posedge clk or posedge rst_cpu) begin
        if (rst_cpu) begin
            wb_req_o <= '0;
            done     <= 1'b0;
            acc_o    <= 8'd0;
            ptr_o    <= 16'd0;
            port_o   <= 8'd0;
        end else begin
            if (wb_req_o.cyc) begin
                if (wb_rsp_i.ack) begin
                    wb_req_o.cyc <= 1'b0;
                    wb_req_o.stb <= 1'b0;
                    done         <= 1'b1;
                    if (!wb_req_o.we) begin
                        acc_o <= rd_byte;
                    end
                end
            end else if (busy_o) begin
                // Open the cycle from committed ptr and acc
                wb_req_o.cyc <= 1'b1;
                wb_req_o.stb <= 1'b1;
                wb_req_o.we  <= mem_wr_i;
                wb_req_o.sel <= ptr_o[0] ? 2'b10 : 2'b01;
                wb_req_o.adr <= ptr_o[15:1];
                wb_req_o.dat <= {acc_o, acc_o};
            end
            if (cen_i && !busy_o) begin
                // Next instruction arrives on this enable
                done <= 1'b0;
                if (valid_i && wr_acc_i) begin
                    acc_o <= value_i[7:0];
                end
                if (valid_i && wr_ptr_i) begin
                    ptr_o <= value_i;
                end
                if (valid_i && wr_port_i) begin
                    port_o <= value_i[7:0];
                end
            end
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst_cpu)
        wb_req_o.stb |-> wb_req_o.cyc);

    // Request frozen while the RAM is not ready
    a_req_stable: assert property (@(posedge clk) disable iff (rst_cpu)
        (wb_req_o.stb && !wb_rsp_i.ack) |=> $stable(wb_req_o));

endmodule

//--- rtl/mcu_host_if.sv
/*
  MCU coprocessor top
  Clock-enable divider, DMA status synchronizer and bus-request flag
  around the decode, execute and result stages
*/
`timescale 1ns/1ns
`include "mcu_params.svh"

module mcu_host_if import mcu_isa_pkg::*, mcu_bus_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_cpu,
    // Program loader
    input  logic                    prog_we_i,
    input  logic [`MCU_PROG_AW-1:0] prog_addr_i,
    input  logic [15:0]             prog_data_i,
    // Main CPU
    input  logic                    dma_on_n_i,
    output logic                    bus_req_n_o,
    output wb_req_s                 wb_req_o,
    input  wb_rsp_s                 wb_rsp_i,
    output logic [7:0]              port_o
);

    localparam int CW = $clog2(`MCU_CEN_DIV + 1);

    logic [CW-1:0]           cen_cnt;
    logic                    cen;
    logic                    dma_s1;
    logic                    dma_s2;
    logic                    dma_last;
    logic                    req_flag;
    logic                    stall;
    logic                    busy;
    logic                    hold;
    logic                    redirect;
    logic                    irq_clr;
    logic [`MCU_PROG_AW-1:0] target;
    logic [`MCU_PROG_AW-1:0] fetch_addr;
    insn_u                   fetch_data;
    ctrl_s                   ctrl;
    logic                    wr_acc;
    logic                    wr_ptr;
    logic                    wr_port;
    logic [15:0]             value;
    logic                    mem_rd;
    logic                    mem_wr;
    logic                    ex_valid;
    logic [7:0]              acc;
    logic [15:0]             ptr;

    // One enable every MCU_CEN_DIV clocks
    always_ff @(posedge clk or posedge rst_cpu) begin
        if (rst_cpu) begin
            cen_cnt <= '0;
        end else begin
            cen_cnt <= (cen_cnt == CW'(`MCU_CEN_DIV - 1)) ? '0 : cen_cnt + 1'b1;
        end
    end
    assign cen = cen_cnt == '0;

    // Idle high so reset sees no edge
    always_ff @(posedge clk or posedge rst_cpu) begin
        if (rst_cpu) begin
            dma_s1   <= 1'b1;
            dma_s2   <= 1'b1;
            dma_last <= 1'b1;
            req_flag <= 1'b0;
        end else begin
            dma_s1   <= dma_on_n_i;
            dma_s2   <= dma_s1;
            dma_last <= dma_s2;
            // Clear beats a new DMA end
            if (irq_clr) begin
                req_flag <= 1'b0;
            end else if (dma_s2 && !dma_last) begin
                req_flag <= 1'b1;
            end
        end
    end
    assign bus_req_n_o = ~req_flag;

    // Bus wait freezes all, WINT only the front end
    assign stall = busy || hold;

    mcu_prog_mem u_mem (
        .clk         ( clk          ),
        .prog_we_i   ( prog_we_i    ),
        .prog_addr_i ( prog_addr_i  ),
        .prog_data_i ( prog_data_i  ),
        .rd_addr_i   ( fetch_addr   ),
        .rd_data_o   ( fetch_data   )
    );

    mcu_decode u_decode (
        .clk         ( clk          ),
        .rst_cpu     ( rst_cpu      ),
        .cen_i       ( cen          ),
        .stall_i     ( stall        ),
        .redirect_i  ( redirect     ),
        .target_i    ( target       ),
        .mem_addr_o  ( fetch_addr   ),
        .mem_data_i  ( fetch_data   ),
        .ctrl_o      ( ctrl         )
    );

    mcu_execute u_execute (
        .clk         ( clk          ),
        .rst_cpu     ( rst_cpu      ),
        .cen_i       ( cen          ),
        .stall_i     ( busy         ),
        .irq_pend_i  ( req_flag     ),
        .ctrl_i      ( ctrl         ),
        .acc_i       ( acc          ),
        .ptr_i       ( ptr          ),
        .redirect_o  ( redirect     ),
        .target_o    ( target       ),
        .irq_clr_o   ( irq_clr      ),
        .hold_o      ( hold         ),
        .wr_acc_o    ( wr_acc       ),
        .wr_ptr_o    ( wr_ptr       ),
        .wr_port_o   ( wr_port      ),
        .value_o     ( value        ),
        .mem_rd_o    ( mem_rd       ),
        .mem_wr_o    ( mem_wr       ),
        .valid_o     ( ex_valid     )
    );

    mcu_result u_result (
        .clk         ( clk          ),
        .rst_cpu     ( rst_cpu      ),
        .cen_i       ( cen          ),
        .wr_acc_i    ( wr_acc       ),
        .wr_ptr_i    ( wr_ptr       ),
        .wr_port_i   ( wr_port      ),
        .value_i     ( value        ),
        .mem_rd_i    ( mem_rd       ),
        .mem_wr_i    ( mem_wr       ),
        .valid_i     ( ex_valid     ),
        .wb_req_o    ( wb_req_o     ),
        .wb_rsp_i    ( wb_rsp_i     ),
        .acc_o       ( acc          ),
        .ptr_o       ( ptr          ),
        .port_o      ( port_o       ),
        .busy_o      ( busy         )
    );

endmodule

//--- test/mcu_tb.sv
/*
  MCU coprocessor testbench
  Loads a short program, models the shared RAM with random ack delays
  and checks the bus, the request line and the output port by assertions
*/
`timescale 1ns/1ns
`include "mcu_params.svh"

module mcu_tb import mcu_isa_pkg::*, mcu_bus_pkg::*; ();

    localparam int          CLK_NS    = 4;
    localparam int          PROG_LEN  = 16;
    localparam int          MAX_ACK   = 3;
    localparam int          HALT_PC   = 15;
    localparam logic [15:0] BASE_PTR  = 16'h02a5;
    localparam int          WDOG_CYC  = 2 * PROG_LEN + 2 + 16 * `MCU_CEN_DIV
                                        + 3 * PROG_LEN * (`MCU_CEN_DIV + MAX_ACK + 3) + 50;

    logic                    clk;
    logic                    rst_cpu;
    logic                    prog_we_i;
    logic [`MCU_PROG_AW-1:0] prog_addr_i;
    logic [15:0]             prog_data_i;
    logic                    dma_on_n_i;
    logic                    bus_req_n_o;
    wb_req_s                 wb_req_o;
    wb_rsp_s                 wb_rsp_i;
    logic [7:0]              port_o;

    // Shared RAM model state
    logic [15:0] ram [2**`MCU_XADDR_W];
    logic [15:0] prog [PROG_LEN];
    int          errors;
    int          wr_count;
    int          wait_cnt;
    logic        pending;
    logic        wr_open;
    logic [1:0]  wr_sel;
    logic [15:0] wr_dat;
    logic [14:0] wr_adr;
    logic [7:0]  last_wbyte;
    logic        req_seen;
    logic [15:0] exp_ptr;
    logic [15:0] exp_word;
    logic [7:0]  exp_byte;

    mcu_host_if UUT (
        .clk         ( clk         ),
        .rst_cpu     ( rst_cpu     ),
        .prog_we_i   ( prog_we_i   ),
        .prog_addr_i ( prog_addr_i ),
        .prog_data_i ( prog_data_i ),
        .dma_on_n_i  ( dma_on_n_i  ),
        .bus_req_n_o ( bus_req_n_o ),
        .wb_req_o    ( wb_req_o    ),
        .wb_rsp_i    ( wb_rsp_i    ),
        .port_o      ( port_o      )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic [15:0] enc_imm(opcode_e op, logic [7:0] imm);
        return {op, 4'h0, imm};
    endfunction

    function automatic logic [15:0] enc_adr(opcode_e op, logic [11:0] adr);
        return {op, adr};
    endfunction

    // Expected write from the model's own memory, byte at ptr plus 5
    always_comb begin
        exp_ptr  = BASE_PTR + 16'(wr_count);
        exp_word = ram[exp_ptr[15:1]];
        exp_byte = (exp_ptr[0] ? exp_word[15:8] : exp_word[7:0]) + 8'd5;
    end

    // RAM responder, ack after 0 to 3 cycles, write lands after the ack
    always @(negedge clk) begin
        if (rst_cpu) begin
            wb_rsp_i <= '0;
            pending  <= 1'b0;
            wr_open  <= 1'b0;
        end else if (wb_rsp_i.ack) begin
            wb_rsp_i.ack <= 1'b0;
            if (wr_open) begin
                // Byte the port should show later, before memory changes
                last_wbyte <= exp_byte;
                if (wr_sel[1]) ram[wr_adr][15:8] = wr_dat[15:8];
                if (wr_sel[0]) ram[wr_adr][7:0] = wr_dat[7:0];
                wr_count   <= wr_count + 1;
                wr_open    <= 1'b0;
            end
        end else if (wb_req_o.cyc && wb_req_o.stb) begin
            if (!pending) begin
                wait_cnt = int'($urandom % (MAX_ACK + 1));
                pending  <= 1'b1;
            end
            if (wait_cnt == 0) begin
                pending      <= 1'b0;
                wb_rsp_i.ack <= 1'b1;
                wb_rsp_i.dat <= ram[wb_req_o.adr];
                wr_open      <= wb_req_o.we;
                wr_sel       <= wb_req_o.sel;
                wr_dat       <= wb_req_o.dat;
                wr_adr       <= wb_req_o.adr;
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (!bus_req_n_o) req_seen <= 1'b1;
    end

    // Reset state, also one cycle after release
    a_reset_state: assert property (@(posedge clk) (rst_cpu || $past(rst_cpu)) |->
        (!wb_req_o.cyc && !wb_req_o.stb && bus_req_n_o && port_o == 8'h00))
        else begin
            errors++;
            $display("Error: reset state cyc=%h stb=%h bus_req_n_o=%h port_o=%h",
                     wb_req_o.cyc, wb_req_o.stb, bus_req_n_o, port_o);
        end

    // Request line low exactly 3 clk after a DMA end
    a_req_after_dma: assert property (@(posedge clk) disable iff (rst_cpu)
        ($past(dma_on_n_i, 3) && !$past(dma_on_n_i, 4)) |-> !bus_req_n_o)
        else begin
            errors++;
            $display("Error: bus_req_n_o = %h, expected %h", bus_req_n_o, 1'b0);
        end

    // Never earlier, and never without an edge
    a_req_only_dma: assert property (@(posedge clk) disable iff (rst_cpu)
        $fell(bus_req_n_o) |-> ($past(dma_on_n_i, 3) && !$past(dma_on_n_i, 4)))
        else begin
            errors++;
            $display("Error: bus_req_n_o = %h, expected %h", bus_req_n_o, 1'b1);
        end

    a_no_early_bus: assert property (@(posedge clk) disable iff (rst_cpu)
        wb_req_o.cyc |-> req_seen)
        else begin
            errors++;
            $display("Bus cycle started before the request line was set");
        end

    a_req_hold: assert property (@(posedge clk) disable iff (rst_cpu)
        (wb_req_o.stb && !wb_rsp_i.ack) |=> $stable(wb_req_o))
        else begin
            errors++;
            $display("Error: wb_req_o = %h, expected %h", wb_req_o, $past(wb_req_o));
        end

    a_wr_adr: assert property (@(posedge clk) disable iff (rst_cpu)
        (wb_req_o.stb && wb_req_o.we && wb_rsp_i.ack) |-> wb_req_o.adr == exp_ptr[15:1])
        else begin
            errors++;
            $display("Error: wb_req_o.adr = %h, expected %h", wb_req_o.adr, exp_ptr[15:1]);
        end

    a_wr_sel: assert property (@(posedge clk) disable iff (rst_cpu)
        (wb_req_o.stb && wb_req_o.we && wb_rsp_i.ack) |->
        wb_req_o.sel == (exp_ptr[0] ? 2'b10 : 2'b01))
        else begin
            errors++;
            $display("Error: wb_req_o.sel = %h, expected %h", wb_req_o.sel,
                     exp_ptr[0] ? 2'b10 : 2'b01);
        end

    a_wr_dat: assert property (@(posedge clk) disable iff (rst_cpu)
        (wb_req_o.stb && wb_req_o.we && wb_rsp_i.ack) |->
        wb_req_o.dat == {exp_byte, exp_byte})
        else begin
            errors++;
            $display("Error: wb_req_o.dat = %h, expected %h", wb_req_o.dat,
                     {exp_byte, exp_byte});
        end

    // Run limit from program length, enable rate and ack delay
    initial begin
        #(WDOG_CYC * CLK_NS);
        $display("Watchdog expired, the program did not reach its end");
        $display("Errors: %0d", errors + 1);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h949d));
        errors      = 0;
        wr_count    = 0;
        wait_cnt    = 0;
        req_seen    = 1'b0;
        last_wbyte  = 8'h00;
        rst_cpu     = 1'b1;
        prog_we_i   = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        dma_on_n_i  = 1'b1;
        wb_rsp_i    = '0;
        for (int i = 0; i < 2**`MCU_XADDR_W; i++) begin
            ram[i] = 16'(i * 16'h2f1b) ^ {i[7:0], i[14:7]};
        end
        prog = '{enc_imm(OP_WINT, 8'h00), enc_adr(OP_LDP, BASE_PTR[11:0]),
                 enc_imm(OP_RDX, 8'h00),  enc_imm(OP_ADDI, 8'h05),
                 enc_imm(OP_WRX, 8'h00),  enc_imm(OP_INCP, 8'h00),
                 enc_imm(OP_RDX, 8'h00),  enc_imm(OP_ADDI, 8'h05),
                 enc_imm(OP_WRX, 8'h00),  enc_imm(OP_OUT, 8'h00),
                 enc_imm(OP_CLRI, 8'h00), enc_imm(OP_LDI, 8'h03),
                 enc_imm(OP_ADDI, 8'hff), enc_adr(OP_JNZ, 12'd12),
                 enc_imm(OP_OUT, 8'h00),  enc_adr(OP_JMP, 12'(HALT_PC))};
        // Loader runs while the core is held in reset
        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge clk);
            prog_we_i   = 1'b1;
            prog_addr_i = `MCU_PROG_AW'(i);
            prog_data_i = prog[i];
        end
        @(negedge clk);
        prog_we_i = 1'b0;
        repeat (2) @(negedge clk);
        rst_cpu = 1'b0;
        // Core parks on WINT
        repeat (8 * `MCU_CEN_DIV) @(negedge clk);
        dma_on_n_i = 1'b0;
        repeat (4) @(negedge clk);
        dma_on_n_i = 1'b1;
        wait (!bus_req_n_o);
        wait (bus_req_n_o);
        @(negedge clk);
        assert (port_o == last_wbyte) else begin
            errors++;
            $display("Error: port_o = %h, expected %h", port_o, last_wbyte);
        end
        wait (UUT.fetch_addr == `MCU_PROG_AW'(HALT_PC));
        repeat (3 * `MCU_CEN_DIV) @(negedge clk);
        assert (port_o == 8'h00) else begin
            errors++;
            $display("Error: port_o = %h, expected %h", port_o, 8'h00);
        end
        assert (wr_count == 2) else begin
            errors++;
            $display("Error: wr_count = %h, expected %h", wr_count, 2);
        end
        // Next DMA end raises the request again
        dma_on_n_i = 1'b0;
        repeat (4) @(negedge clk);
        dma_on_n_i = 1'b1;
        repeat (6) @(negedge clk);
        assert (!bus_req_n_o) else begin
            errors++;
            $display("Error: bus_req_n_o = %h, expected %h", bus_req_n_o, 1'b0);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+include
rtl/mcu_bus_pkg.sv
rtl/mcu_isa_pkg.sv
rtl/mcu_prog_mem.sv
rtl/mcu_decode.sv
rtl/mcu_execute.sv
rtl/mcu_result.sv
rtl/mcu_host_if.sv
test/mcu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MCU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mcu_tb -f list.f -o mcu_sim

out=$(./obj_dir/mcu_sim)
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS"
